// ==== Makefile ====
TOP = am_lock_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	elif ! grep -q "No errors" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module am_lock_top

clean:
	rm -rf obj_dir $(LOG)

// ==== design/am_lock_comparator.sv ====
`timescale 1ns/1ps
`include "am_lock_config.svh"

module am_lock_comparator
(
	input  am_lock_pkg::am_value_t  i_am_value,
	input  am_lock_pkg::lane_mask_t i_match_mask,
	input  logic                    i_enable_mask,
	input  logic                    i_timer_done,
	output logic                    o_match,
	output am_lock_pkg::lane_mask_t o_match_vector
);

	// standard 100G lane markers, lane 0 in the low entry
	localparam logic [`AM_LANES-1:0][`AM_LEN-1:0] AM_TABLE =
	{
		48'hC0F0E53F0F1A, // lane 19
		48'h5F662AA099D5,
		48'hADD6B7522948,
		48'hC4314C3BCEB3,
		48'h3536CDCAC932,
		48'h83C7CA7C3835,
		48'h1AF8BDE50742,
		48'h5CB9B2A3464D,
		48'hB99155466EAA,
		48'hFD6C99029366, // lane 10
		48'h68C9FB973604,
		48'hA024765FDB89,
		48'h7B456684BA99,
		48'h9A4A2665B5D9,
		48'hDD14C222EB3D,
		48'hF507090AF8F6,
		48'h4D957BB26A84,
		48'h594BE8A6B417,
		48'h9D718E628E71,
		48'hC168213E97DE  // lane 0
	};

	logic compare_en;

	// all lanes in parallel
	always_comb
	begin
		for (int i = 0; i < `AM_LANES; i++)
			o_match_vector[i] = i_match_mask[i] && (AM_TABLE[i] == i_am_value);
	end

	assign compare_en = i_enable_mask || i_timer_done; // search or expected slot
	assign o_match    = (|o_match_vector) && compare_en;

endmodule

// ==== design/am_lock_config.svh ====
`ifndef AM_LOCK_CONFIG_SVH
`define AM_LOCK_CONFIG_SVH

// marker field taken from one 66-bit block
`define AM_LEN        48
`define AM_LANES      20

// valid blocks between markers, standard value is 16384
`define AM_PERIOD     64
`define AM_CNT_W      14

// good markers after the first one before lock
`define AM_GOOD_COUNT 2

// consecutive bad markers that drop lock
`define AM_BAD_LIMIT  4

`endif

// ==== design/am_lock_fsm.sv ====
`timescale 1ns/1ps
`include "am_lock_config.svh"

module am_lock_fsm
(
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_valid,
	input  logic                    i_timer_done,
	input  logic                    i_match,
	input  am_lock_pkg::lane_mask_t i_match_vector,
	output am_lock_pkg::lane_mask_t o_match_mask,
	output logic                    o_enable_mask,
	output logic                    o_restart,
	output am_lock_pkg::am_status_t o_status
);

	localparam int GOOD_W = $clog2(`AM_GOOD_COUNT + 1);
	localparam int BAD_W  = $clog2(`AM_BAD_LIMIT + 1);

	am_lock_pkg::lock_state_t state;
	am_lock_pkg::lane_mask_t  match_mask;
	am_lock_pkg::lane_id_t    lane_id;   // candidate lane
	am_lock_pkg::lane_id_t    found_id;
	am_lock_pkg::am_status_t  status;
	logic [GOOD_W-1:0]        good_cnt;
	logic [BAD_W-1:0]         bad_cnt;
	logic                     searching;
	logic                     check;     // valid block at expected slot
	logic                     last_good;
	logic                     last_bad;

	assign check     = i_valid && i_timer_done;
	assign last_good = (good_cnt == GOOD_W'(`AM_GOOD_COUNT - 1));
	assign last_bad  = (bad_cnt == BAD_W'(`AM_BAD_LIMIT - 1));

	// one-hot to lane number
	always_comb
	begin
		found_id = '0;
		for (int i = `AM_LANES - 1; i >= 0; i--)
			if (i_match_vector[i])
				found_id = am_lock_pkg::lane_id_t'(i);
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			state      <= am_lock_pkg::SEARCH;
			match_mask <= '1;
			lane_id    <= '0;
			good_cnt   <= '0;
			bad_cnt    <= '0;
			searching  <= 1'b1;
			status     <= '0;
		end
		else
		begin
			status.am_strobe <= 1'b0; // single cycle pulse

			case (state)
				am_lock_pkg::SEARCH:
				begin
					if (i_valid && i_match)
					begin
						match_mask <= i_match_vector;
						lane_id    <= found_id;
						good_cnt   <= '0;
						bad_cnt    <= '0;
						searching  <= 1'b0; // timer runs from this block
						state      <= am_lock_pkg::COUNT;
					end
				end

				am_lock_pkg::COUNT:
				begin
					if (check)
					begin
						if (!i_match)
						begin
							match_mask <= '1;
							good_cnt   <= '0;
							searching  <= 1'b1;
							state      <= am_lock_pkg::SEARCH;
						end
						else if (last_good)
						begin
							good_cnt         <= '0;
							bad_cnt          <= '0;
							status.lock      <= 1'b1;
							status.lane_id   <= lane_id;
							status.am_strobe <= 1'b1;
							state            <= am_lock_pkg::LOCKED;
						end
						else
							good_cnt <= good_cnt + 1'b1;
					end
				end

				am_lock_pkg::LOCKED:
				begin
					if (check)
					begin
						if (i_match)
						begin
							bad_cnt          <= '0;
							status.am_strobe <= 1'b1;
						end
						else if (last_bad)
						begin
							// lost the lane, hunt again on all markers
							match_mask     <= '1;
							lane_id        <= '0;
							good_cnt       <= '0;
							bad_cnt        <= '0;
							searching      <= 1'b1;
							status.lock    <= 1'b0;
							status.lane_id <= '0;
							state          <= am_lock_pkg::SEARCH;
						end
						else
							bad_cnt <= bad_cnt + 1'b1;
					end
				end

				default:
				begin
					match_mask <= '1;
					searching  <= 1'b1;
					state      <= am_lock_pkg::SEARCH;
				end
			endcase
		end
	end

	assign o_match_mask  = match_mask;
	assign o_enable_mask = searching;
	assign o_restart     = searching; // timer held clear while searching
	assign o_status      = status;

endmodule

// ==== design/am_lock_pkg.sv ====
`include "am_lock_config.svh"

package am_lock_pkg;

	typedef logic [`AM_LEN-1:0]            am_value_t;  // M0..M2 over M4..M6
	typedef logic [`AM_LANES-1:0]          lane_mask_t; // one bit per pcs lane
	typedef logic [$clog2(`AM_LANES)-1:0]  lane_id_t;
	typedef logic [`AM_CNT_W-1:0]          block_cnt_t;

	// one block from block sync
	typedef struct packed
	{
		logic        valid;
		logic [1:0]  header;  // checked upstream
		logic [63:0] payload;
	} am_block_t;

	typedef struct packed
	{
		logic     lock;
		lane_id_t lane_id;    // only meaningful while locked
		logic     am_strobe;
	} am_status_t;

	typedef enum logic [1:0]
	{
		SEARCH,
		COUNT,
		LOCKED
	} lock_state_t;

endpackage

// ==== design/am_lock_timer.sv ====
`timescale 1ns/1ps
`include "am_lock_config.svh"

module am_lock_timer
(
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_valid,
	input  logic i_restart,
	output logic o_timer_done
);

	localparam am_lock_pkg::block_cnt_t LAST_SLOT =
		am_lock_pkg::block_cnt_t'(`AM_PERIOD - 1);

	am_lock_pkg::block_cnt_t count; // valid blocks since the marker, minus one
	logic                    at_last;

	assign at_last      = (count == LAST_SLOT);
	assign o_timer_done = i_valid && at_last;

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			count <= '0;
		else if (i_valid)
		begin
			if (i_restart || at_last)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

endmodule

// ==== design/am_lock_top.sv ====
`timescale 1ns/1ps

module am_lock_top
(
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  am_lock_pkg::am_block_t  i_block,
	output am_lock_pkg::am_status_t o_status
);

	am_lock_pkg::am_value_t  am_value;
	am_lock_pkg::lane_mask_t match_mask;
	am_lock_pkg::lane_mask_t match_vector;
	logic                    block_valid;
	logic                    enable_mask;
	logic                    timer_done;
	logic                    match;
	logic                    restart;

	assign block_valid = i_block.valid;

	// M0..M2 above M4..M6, bip bytes dropped
	assign am_value = {i_block.payload[55:32], i_block.payload[23:0]};

	am_lock_comparator u_am_lock_comparator
	(
		.i_am_value     (am_value),
		.i_match_mask   (match_mask),
		.i_enable_mask  (enable_mask),
		.i_timer_done   (timer_done),
		.o_match        (match),
		.o_match_vector (match_vector)
	);

	am_lock_timer u_am_lock_timer
	(
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_valid      (block_valid),
		.i_restart    (restart),
		.o_timer_done (timer_done)
	);

	am_lock_fsm u_am_lock_fsm
	(
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_valid        (block_valid),
		.i_timer_done   (timer_done),
		.i_match        (match),
		.i_match_vector (match_vector),
		.o_match_mask   (match_mask),
		.o_enable_mask  (enable_mask),
		.o_restart      (restart),
		.o_status       (o_status)
	);

endmodule

// ==== tests/am_lock_tb.sv ====
`timescale 1ns/1ps
`include "am_lock_config.svh"

module am_lock_tb;

	typedef struct packed
	{
		int          lane;        // lane whose markers are sent
		int          num_markers; // marker slots, AM_PERIOD valid blocks apart
		logic [15:0] bad_mask;    // slots that carry a bad marker
		logic        swap;        // bad slot carries another lane's marker
		int          idle_pct;    // chance of an idle cycle before a block
		logic        final_lock;
		int          final_lane;
	} row_t;

	logic                    i_clk;
	logic                    i_rst;
	am_lock_pkg::am_block_t  i_block;
	am_lock_pkg::am_status_t o_status;

	row_t  rows[$];
	string names[$];
	string cur_name;

	// reference model
	am_lock_pkg::lock_state_t m_state;
	int                       m_lane;
	int                       m_pos;   // valid blocks since the last marker
	int                       m_good;
	int                       m_bad;
	logic                     exp_lock;
	int                       exp_lane;
	logic                     exp_strobe;

	// lane markers as M0 M1 M2 M4 M5 M6 with lane 0 first
	am_lock_pkg::am_value_t am_table [`AM_LANES] = '{
		48'hC168213E97DE, 48'h9D718E628E71, 48'h594BE8A6B417, 48'h4D957BB26A84,
		48'hF507090AF8F6, 48'hDD14C222EB3D, 48'h9A4A2665B5D9, 48'h7B456684BA99,
		48'hA024765FDB89, 48'h68C9FB973604, 48'hFD6C99029366, 48'hB99155466EAA,
		48'h5CB9B2A3464D, 48'h1AF8BDE50742, 48'h83C7CA7C3835, 48'h3536CDCAC932,
		48'hC4314C3BCEB3, 48'hADD6B7522948, 48'h5F662AA099D5, 48'hC0F0E53F0F1A
	};

	am_lock_top dut
	(
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_block  (i_block),
		.o_status (o_status)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp)
		begin
			$display("mismatch in %s, %s: expected %0h, actual %0h", cur_name, what, exp, act);
			$display("Errors found");
			$fatal(1, "check failed");
		end
	endtask

	// bytes M0..M2 and M4..M6 of the payload
	function automatic am_lock_pkg::am_value_t field_of(input logic [63:0] p);
		return {p[55:32], p[23:0]};
	endfunction

	function automatic int lane_of(input am_lock_pkg::am_value_t v);
		int hit;
		hit = -1;
		for (int i = 0; i < `AM_LANES; i++)
			if (am_table[am_lock_pkg::lane_id_t'(i)] == v)
				hit = i;
		return hit;
	endfunction

	task automatic random_data(output logic [63:0] p);
		do
			p = {$urandom, $urandom};
		while (lane_of(field_of(p)) >= 0); // never a marker by accident
	endtask

	task automatic model_reset();
		m_state    = am_lock_pkg::SEARCH;
		m_lane     = 0;
		m_pos      = 0;
		m_good     = 0;
		m_bad      = 0;
		exp_lock   = 1'b0;
		exp_lane   = 0;
		exp_strobe = 1'b0;
	endtask

	task automatic model_step(input am_lock_pkg::am_block_t blk);
		int   hit;
		logic at_slot;
		exp_strobe = 1'b0;
		if (blk.valid)
		begin
			hit     = lane_of(field_of(blk.payload));
			at_slot = 1'b0;
			if (m_state != am_lock_pkg::SEARCH)
			begin
				m_pos++;
				if (m_pos == `AM_PERIOD)
				begin
					at_slot = 1'b1;
					m_pos   = 0;
				end
			end
			case (m_state)
				am_lock_pkg::SEARCH:
				begin
					if (hit >= 0)
					begin
						m_lane  = hit;
						m_pos   = 0;
						m_good  = 0;
						m_bad   = 0;
						m_state = am_lock_pkg::COUNT;
					end
				end
				am_lock_pkg::COUNT:
				begin
					if (at_slot && hit != m_lane)
						m_state = am_lock_pkg::SEARCH;
					else if (at_slot)
					begin
						m_good++;
						if (m_good == `AM_GOOD_COUNT)
						begin
							exp_lock   = 1'b1;
							exp_lane   = m_lane;
							exp_strobe = 1'b1;
							m_bad      = 0;
							m_state    = am_lock_pkg::LOCKED;
						end
					end
				end
				am_lock_pkg::LOCKED:
				begin
					if (at_slot && hit == m_lane)
					begin
						m_bad      = 0;
						exp_strobe = 1'b1;
					end
					else if (at_slot)
					begin
						m_bad++;
						if (m_bad == `AM_BAD_LIMIT)
						begin
							exp_lock = 1'b0;
							exp_lane = 0;
							m_state  = am_lock_pkg::SEARCH;
						end
					end
				end
				default:
					m_state = am_lock_pkg::SEARCH;
			endcase
		end
	endtask

	// outputs seen at the falling edge hold the previous block's result
	task automatic send_block(input am_lock_pkg::am_block_t blk);
		@(posedge i_clk);
		i_block <= blk;
		@(negedge i_clk);
		check_value("lock", 32'(exp_lock), 32'(o_status.lock));
		check_value("lane_id", 32'(exp_lane), 32'(o_status.lane_id));
		check_value("am_strobe", 32'(exp_strobe), 32'(o_status.am_strobe));
		model_step(blk);
	endtask

	task automatic idle_cycle();
		am_lock_pkg::am_block_t blk;
		blk.valid   = 1'b0;
		blk.header  = 2'b00;
		blk.payload = {$urandom, $urandom};
		send_block(blk);
	endtask

	task automatic send_valid(input logic [63:0] p, input logic [1:0] hdr, input int idle_pct);
		am_lock_pkg::am_block_t blk;
		int                     g;
		for (g = 0; g < 4 && int'($urandom_range(0, 99)) < idle_pct; g++)
			idle_cycle();
		blk.valid   = 1'b1;
		blk.header  = hdr;
		blk.payload = p;
		send_block(blk);
	endtask

	task automatic send_data(input int idle_pct);
		logic [63:0] p;
		random_data(p);
		send_valid(p, 2'b01, idle_pct);
	endtask

	task automatic send_slot(input row_t row, input int s);
		am_lock_pkg::am_value_t v;
		logic [63:0]            p;
		logic                   missing;
		missing = 1'b0;
		v       = am_table[am_lock_pkg::lane_id_t'(row.lane)];
		if (row.bad_mask[s[3:0]])
		begin
			if (row.swap)
				v = am_table[am_lock_pkg::lane_id_t'((row.lane + 7) % `AM_LANES)];
			else if ($urandom_range(0, 1) == 0)
				v = v ^ (48'd1 << $urandom_range(0, 47)); // one flipped bit
			else
				missing = 1'b1;
		end
		if (missing)
			random_data(p);
		else
			p = {8'($urandom), v[47:24], 8'($urandom), v[23:0]};
		send_valid(p, missing ? 2'b01 : 2'b10, row.idle_pct);
	endtask

	task automatic apply_reset();
		@(posedge i_clk);
		i_rst   <= 1'b1;
		i_block <= '0;
		repeat (3) @(posedge i_clk);
		i_rst <= 1'b0;
		model_reset();
	endtask

	task automatic add_row(input string name, input int lane, input int num_markers,
		input logic [15:0] bad_mask, input logic swap, input int idle_pct,
		input logic final_lock, input int final_lane);
		row_t r;
		r.lane        = lane;
		r.num_markers = num_markers;
		r.bad_mask    = bad_mask;
		r.swap        = swap;
		r.idle_pct    = idle_pct;
		r.final_lock  = final_lock;
		r.final_lane  = final_lane;
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic build_table();
		add_row("idle_random",     0,  4,  16'h000f, 1'b0, 30, 1'b0, 0);
		add_row("lock_lane0",      0,  3,  16'h0000, 1'b0, 0,  1'b1, 0);
		add_row("lock_lane10",     10, 5,  16'h0000, 1'b0, 25, 1'b1, 10);
		add_row("lock_lane19",     19, 4,  16'h0000, 1'b0, 50, 1'b1, 19);
		add_row("count_miss",      5,  4,  16'h0002, 1'b0, 20, 1'b0, 0);
		add_row("count_relock",    5,  5,  16'h0002, 1'b0, 20, 1'b1, 5);
		add_row("bad_recover",     7,  10, 16'h03b8, 1'b0, 15, 1'b1, 7);
		add_row("bad_limit",       12, 7,  16'h0078, 1'b0, 15, 1'b0, 0);
		add_row("drop_relock",     14, 10, 16'h0078, 1'b0, 10, 1'b1, 14);
		add_row("other_lane_keep", 3,  6,  16'h0038, 1'b1, 10, 1'b1, 3);
		add_row("other_lane_drop", 3,  7,  16'h0078, 1'b1, 10, 1'b0, 0);
		add_row("swap_first",      16, 5,  16'h0001, 1'b1, 20, 1'b1, 16);
	endtask

	task automatic run_row(input int r);
		row_t row;
		int   lead;
		int   s;
		row      = rows[r];
		cur_name = names[r];
		apply_reset();
		lead = int'($urandom_range(0, 6));
		repeat (lead) send_data(row.idle_pct);
		for (s = 0; s < row.num_markers; s++)
		begin
			send_slot(row, s);
			repeat (`AM_PERIOD - 1) send_data(row.idle_pct);
		end
		idle_cycle(); // result of the last block now visible
		check_value("final lock", 32'(row.final_lock), 32'(o_status.lock));
		check_value("final lane_id", 32'(row.final_lane), 32'(o_status.lane_id));
	endtask

	initial
	begin
		i_rst   <= 1'b1;
		i_block <= '0;
		void'($urandom(32'hce32_ce09));
		model_reset();
		build_table();
		for (int r = 0; r < rows.size(); r++)
			run_row(r);
		$display("No errors");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+design
design/am_lock_pkg.sv
design/am_lock_comparator.sv
design/am_lock_timer.sv
design/am_lock_fsm.sv
design/am_lock_top.sv
tests/am_lock_tb.sv
